// File: erx_frame_track.sv
`timescale 1ns/100ps
`default_nettype none

module erx_frame_track
  (
   input  wire                        rx_lclk,
   input  wire                        erx_io_nreset,
   input  wire                        lane_frame,
   input  wire [erx_pkg::word_w-1:0]  lane_word,
   output erx_pkg::beat_t             beat
   );

   import erx_pkg::*;

   lane_t             lane_q;  // lane after input flop
   logic [beat_n-1:0] ptr;     // position of the word held in lane_q
   logic              cont;    // frame already delivered a packet

   //################################################
   //# input register
   //################################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         lane_q <= '0;
      end
      else
      begin
         lane_q.frame <= lane_frame;
         lane_q.word  <= lane_word;
      end
   end

   //################################################
   //# beat pointer
   //################################################

   // parks on position 0 between frames, so the first word of a frame
   // always lands there; after position 6 it jumps back for a burst
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         ptr <= '0;
      end
      else if (!lane_q.frame)
      begin
         ptr <= beat_n'(1);                  // idle, wait at position 0
      end
      else if (ptr[beat_n-1])
      begin
         ptr <= beat_n'(1) << burst_first;   // anticipate burst
      end
      else
      begin
         ptr <= ptr << 1;                    // middle of frame
      end
   end

   // burst tracking, set once position 6 passed with frame high
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         cont <= 1'b0;
      end
      else if (!lane_q.frame)
      begin
         cont <= 1'b0;                       // frame over
      end
      else if (ptr[beat_n-1])
      begin
         cont <= 1'b1;
      end
   end

   //################################################
   //# beat register
   //################################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         beat <= '0;
      end
      else
      begin
         beat.sel  <= lane_q.frame ? ptr : '0;  // no write outside a frame
         beat.word <= lane_q.word;
         beat.cont <= cont;                     // old value, first packet sees 0
      end
   end

   // at most one sample position written per cycle
   a_sel_onehot: assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      $onehot0(beat.sel))
      else $error("beat pointer not one-hot");

   // last word with frame still up must restart at the burst position
   a_burst_reload: assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      beat.sel[beat_n-1] && lane_q.frame |=> beat.sel[burst_first] && beat.cont)
      else $error("burst did not restart at position %0d", burst_first);

endmodule

`default_nettype wire

// File: erx_link.f
erx_pkg.sv
erx_frame_track.sv
erx_sample_assembler.sv
erx_packet_format.sv
erx_link.sv
erx_link_tb.sv

// File: erx_link.sv
`timescale 1ns/100ps
`default_nettype none

module erx_link
  (
   input  wire                        rx_lclk,        // link clock
   input  wire                        erx_io_nreset,  // async, active low
   input  wire                        lane_frame,
   input  wire [erx_pkg::word_w-1:0]  lane_word,
   output logic                       rx_access,
   output logic                       rx_burst,
   output erx_pkg::emesh_packet_t     rx_packet
   );

   import erx_pkg::*;

   //################################################
   //# stage wires
   //################################################
   beat_t   beat;          // tracked lane beat
   logic    sample_done;   // 112 bit sample complete
   sample_u sample;
   logic    sample_cont;   // burst flag for that sample

   // lane flop, pointer, burst state
   erx_frame_track i_frame_track
     (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .lane_frame    (lane_frame),
      .lane_word     (lane_word),
      .beat          (beat)
      );

   // words into the sample
   erx_sample_assembler i_sample_assembler
     (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .beat          (beat),
      .sample_done   (sample_done),
      .sample        (sample),
      .sample_cont   (sample_cont)
      );

   // sample into emesh packet
   erx_packet_format i_packet_format
     (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .sample_done   (sample_done),
      .sample        (sample),
      .sample_cont   (sample_cont),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
      );

endmodule

`default_nettype wire

// File: erx_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

module erx_link_tb;

   import erx_pkg::*;

   //##################################################
   //# types and table
   //##################################################

   // one frame of the stimulus table
   typedef struct packed {
      logic [1:0] npk;     // complete packets, 1 to 3
      logic [3:0] trunc;   // words before early drop, 0 = full frame
      logic [2:0] gap;     // idle cycles after the frame
   } frame_t;

   // one expected packet from the model
   typedef struct packed {
      emesh_packet_t pkt;
      logic          burst;
      logic [31:0]   at_cyc;   // cycle count when rx_access must be seen
   } exp_t;

   localparam int n_frames = 10;

   frame_t frames [n_frames] = '{
      '{2'd1, 4'd0, 3'd2},   // single packet
      '{2'd3, 4'd0, 3'd1},   // three packet burst
      '{2'd1, 4'd5, 3'd1},   // dropped after 5 words
      '{2'd1, 4'd0, 3'd3},   // clean frame after the drop
      '{2'd2, 4'd0, 3'd1},
      '{2'd1, 4'd9, 3'd2},   // one packet then a partial burst
      '{2'd2, 4'd0, 3'd5},
      '{2'd1, 4'd3, 3'd1},   // very short drop
      '{2'd3, 4'd0, 3'd4},
      '{2'd1, 4'd0, 3'd1}
   };

   //##################################################
   //# dut signals
   //##################################################
   logic          rx_lclk;
   logic          erx_io_nreset;
   logic          lane_frame;
   logic [15:0]   lane_word;
   logic          rx_access;
   logic          rx_burst;
   emesh_packet_t rx_packet;

   // testbench state
   int unsigned   cyc;                // rising edges since start
   int unsigned   limit;              // timeout in cycles, 0 until known
   logic [31:0]   rnd = 32'd93874;    // xorshift state
   exp_t          exp_q [$];          // packets the model expects
   exp_t          got;
   emesh_packet_t last_pkt;           // packet of the last strobe
   logic          last_burst;
   int unsigned   n_rx;

   // model of the sample register
   logic [13:0][7:0] m_bytes;
   int               m_pos;           // next position in the frame
   int               m_npkt;          // packets done in this frame

   erx_link i_erx_link
     (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .lane_frame    (lane_frame),
      .lane_word     (lane_word),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
      );

   initial
   begin
      rx_lclk = 1'b0;
      forever #2 rx_lclk = ~rx_lclk;   // 4 ns period
   end

   always @(posedge rx_lclk)
   begin
      cyc <= cyc + 1;
   end

   //##################################################
   //# helpers
   //##################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // byte rule, byte 2k = low byte of word k
   function automatic emesh_packet_t decode_bytes(input logic [13:0][7:0] b);
      emesh_packet_t p;
      p.ctrlmode = b[1][7:4];
      p.dstaddr  = {b[1][3:0], b[2], b[3], b[4], b[5][7:4]};   // straddles nibbles
      p.datamode = b[5][3:2];
      p.write    = b[5][1];
      p.access   = b[5][0];
      p.data     = {b[6], b[7], b[8], b[9]};
      p.srcaddr  = {b[10], b[11], b[12], b[13]};
      return p;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic compare_value(input string what, input logic [127:0] actual,
                                input logic [127:0] expected);
      if (actual !== expected)
      begin
         abort_run($sformatf("[FAIL] %0t: %s is %h, expected %h",
                             $time, what, actual, expected));
      end
   endtask

   // one lane word into the model, called on the edge that drives it
   task automatic model_word(input logic [15:0] w);
      exp_t e;
      m_bytes[2*m_pos]   = w[7:0];
      m_bytes[2*m_pos+1] = w[15:8];
      if (m_pos == beat_n - 1)
      begin
         e.pkt    = decode_bytes(m_bytes);
         e.burst  = (m_npkt != 0);   // every packet after the first
         e.at_cyc = cyc + 5;         // sampled next edge, then 3 stages
         exp_q.push_back(e);
         m_npkt = m_npkt + 1;
         m_pos  = burst_first;       // burst reuses header bytes
      end
      else
      begin
         m_pos = m_pos + 1;
      end
   endtask

   function automatic int frame_words(input frame_t f);
      if (f.trunc != 0)
      begin
         return int'(f.trunc);
      end
      return 7 + 4 * (int'(f.npk) - 1);
   endfunction

   task automatic send_frame(input frame_t f);
      int nwords;
      int i;
      logic [15:0] w;
      nwords = frame_words(f);
      m_pos  = 0;   // new frame starts at position 0
      m_npkt = 0;
      for (i = 0; i < nwords; i++)
      begin
         @(posedge rx_lclk);
         rnd = xorshift32(rnd);
         w   = rnd[15:0];
         lane_frame <= 1'b1;
         lane_word  <= w;
         model_word(w);
      end
      for (i = 0; i < int'(f.gap); i++)
      begin
         @(posedge rx_lclk);
         rnd = xorshift32(rnd);
         lane_frame <= 1'b0;
         lane_word  <= rnd[31:16];   // junk, must be ignored
      end
   endtask

   //##################################################
   //# output monitor
   //##################################################

   // outputs move on the rising edge, read them mid cycle
   always @(negedge rx_lclk)
   begin
      if (erx_io_nreset)
      begin
         if (rx_access)
         begin
            if (exp_q.size() == 0)
            begin
               abort_run("rx_access strobe arrived with no packet expected");
            end
            else
            begin
               got = exp_q.pop_front();
               compare_value("rx_packet", 128'(rx_packet), 128'(got.pkt));
               compare_value("rx_burst", 128'(rx_burst), 128'(got.burst));
               compare_value("rx_access cycle", 128'(cyc), 128'(got.at_cyc));
               last_pkt   = rx_packet;
               last_burst = rx_burst;
               n_rx       = n_rx + 1;
            end
         end
         else
         begin
            // hold between strobes, zero before the first
            compare_value("held rx_packet", 128'(rx_packet), 128'(last_pkt));
            compare_value("held rx_burst", 128'(rx_burst), 128'(last_burst));
         end
      end
   end

   always @(posedge rx_lclk)
   begin
      if (limit != 0 && cyc >= limit)
      begin
         abort_run($sformatf("simulation timed out after %0d cycles", cyc));
      end
   end

   //##################################################
   //# main sequence
   //##################################################
   initial
   begin
      int total;
      int i;
      erx_io_nreset = 1'b0;
      lane_frame    = 1'b0;
      lane_word     = '0;
      cyc           = 0;
      n_rx          = 0;
      last_pkt      = '0;
      last_burst    = 1'b0;
      m_bytes       = '0;
      m_pos         = 0;
      m_npkt        = 0;
      total = 3 + 4 + 8;   // reset, idle lead-in, drain
      for (i = 0; i < n_frames; i++)
      begin
         total = total + frame_words(frames[i]) + int'(frames[i].gap);
      end
      limit = 2 * total + 50;

      repeat (3) @(posedge rx_lclk);
      erx_io_nreset <= 1'b1;
      repeat (4) @(posedge rx_lclk);   // idle, outputs must stay zero

      for (i = 0; i < n_frames; i++)
      begin
         send_frame(frames[i]);
      end

      // last strobe lands 3 cycles after the last word
      for (i = 0; i < 8 && exp_q.size() != 0; i++)
      begin
         @(posedge rx_lclk);
      end
      @(negedge rx_lclk);

      if (exp_q.size() != 0)
      begin
         abort_run($sformatf("%0d expected packets never arrived", exp_q.size()));
      end
      else
      begin
         $display("received %0d packets in %0d cycles", n_rx, cyc);
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: erx_packet_format.sv
`timescale 1ns/100ps
`default_nettype none

module erx_packet_format
  (
   input  wire                      rx_lclk,
   input  wire                      erx_io_nreset,
   input  wire                      sample_done,
   input  wire erx_pkg::sample_u    sample,
   input  wire                      sample_cont,
   output logic                     rx_access,
   output logic                     rx_burst,
   output erx_pkg::emesh_packet_t   rx_packet
   );

   import erx_pkg::*;

   sample_fields_t f;       // field view of the sample
   emesh_packet_t  pkt_d;   // reordered packet, before the output flop

   assign f = sample.fields;

   //################################################
   //# byte shuffle
   //################################################
   always_comb
   begin
      pkt_d.srcaddr  = {f.src_b3, f.src_b2, f.src_b1, f.src_b0};        // bytes 10..13
      pkt_d.data     = {f.data_b3, f.data_b2, f.data_b1, f.data_b0};    // bytes 6..9
      // dstaddr straddles two nibbles
      pkt_d.dstaddr  = {f.dst_n7, f.dst_b3, f.dst_b2, f.dst_b1, f.dst_n0};
      pkt_d.ctrlmode = f.ctrlmode;   // byte 1 hi
      pkt_d.datamode = f.datamode;
      pkt_d.write    = f.write;
      pkt_d.access   = f.access;     // copied as sent, not the strobe
   end

   //################################################
   //# output register
   //################################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
         rx_packet <= '0;
      end
      else
      begin
         rx_access <= sample_done;   // one cycle strobe
         if (sample_done)
         begin
            rx_packet <= pkt_d;
            rx_burst  <= sample_cont;
         end
      end
   end

   // packet and burst flag only move with the strobe
   a_pkt_hold: assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      !rx_access |-> $stable(rx_packet) && $stable(rx_burst))
      else $error("rx_packet changed without rx_access");

endmodule

`default_nettype wire

// File: erx_pkg.sv
`default_nettype none

package erx_pkg;

   //################################################
   //# link widths
   //################################################
   localparam int word_w      = 16;               // one lane word per rx_lclk
   localparam int beat_n      = 7;                // words in a full packet
   localparam int burst_first = 3;                // burst packets restart here
   localparam int sample_w    = beat_n * word_w;  // 112
   localparam int pw          = 104;              // emesh packet width

   //################################################
   //# lane and beat bundles
   //################################################

   // registered lane input
   typedef struct packed {
      logic              frame;  // frame flag
      logic [word_w-1:0] word;   // lane word
   } lane_t;

   // one word tagged with its frame position
   typedef struct packed {
      logic [beat_n-1:0] sel;    // one-hot position, zero when idle
      logic [word_w-1:0] word;
      logic              cont;   // burst packet, not the first of the frame
   } beat_t;

   // emesh transaction, msb first
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } emesh_packet_t;

   //################################################
   //# sample layout
   //################################################

   // byte n of the sample is word n/2, low byte first
   // multi-byte fields arrive msb first, so they split per byte here
   typedef struct packed {
      logic [7:0] src_b0;     // byte 13, srcaddr[7:0]
      logic [7:0] src_b1;     // byte 12
      logic [7:0] src_b2;     // byte 11
      logic [7:0] src_b3;     // byte 10, srcaddr[31:24]
      logic [7:0] data_b0;    // byte 9, data[7:0]
      logic [7:0] data_b1;    // byte 8
      logic [7:0] data_b2;    // byte 7
      logic [7:0] data_b3;    // byte 6, data[31:24]
      logic [3:0] dst_n0;     // byte 5 hi, dstaddr[3:0]
      logic [1:0] datamode;   // byte 5 [3:2]
      logic       write;      // byte 5 [1]
      logic       access;     // byte 5 [0]
      logic [7:0] dst_b1;     // byte 4, dstaddr[11:4]
      logic [7:0] dst_b2;     // byte 3, dstaddr[19:12]
      logic [7:0] dst_b3;     // byte 2, dstaddr[27:20]
      logic [3:0] ctrlmode;   // byte 1 hi
      logic [3:0] dst_n7;     // byte 1 lo, dstaddr[31:28]
      logic [sample_w-pw-1:0] rsvd;  // byte 0, not carried
   } sample_fields_t;

   // Same 112 bits seen two ways. The assembler fills it word by word
   // through raw, the formatter picks fields out of it.
   typedef union packed {
      logic [sample_w/8-1:0][7:0] raw;     // raw[n] = bits 8n+7:8n
      sample_fields_t             fields;
   } sample_u;

endpackage

`default_nettype wire

// File: erx_sample_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module erx_sample_assembler
  (
   input  wire                   rx_lclk,
   input  wire                   erx_io_nreset,
   input  wire erx_pkg::beat_t   beat,
   output logic                  sample_done,
   output erx_pkg::sample_u      sample,
   output logic                  sample_cont
   );

   import erx_pkg::*;

   logic last_beat;   // word 6 of a packet on the bundle

   assign last_beat = beat.sel[beat_n-1];

   //################################################
   //# sample write
   //################################################

   // each position owns two bytes, low byte first
   // header bytes 0..5 are untouched during a burst and carry over
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < beat_n; i++)
      begin
         if (beat.sel[i])
         begin
            sample.raw[i*(word_w/8) +: word_w/8] <= beat.word;
         end
      end
   end

   //################################################
   //# completion strobe
   //################################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         sample_done <= 1'b0;
         sample_cont <= 1'b0;
      end
      else
      begin
         sample_done <= last_beat;       // same edge writes the last word
         if (last_beat)
         begin
            sample_cont <= beat.cont;    // burst flag of this packet
         end
      end
   end

   // packets are at least four beats apart
   a_done_single: assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      sample_done |=> !sample_done)
      else $error("sample_done high two cycles in a row");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the erx_link testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module erx_link_tb \
   -f erx_link.f \
   -o erx_link_sim

status=0
./obj_dir/erx_link_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, exit status $status"
   exit 1
fi
